//--- Makefile
# verilator build and run of the exe slice testbench

SIM = obj_dir/Vexe_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --top-module exe_tb -f verilog.f

# output goes to the terminal, the status comes from grep
run: compile
	./$(SIM) | tee /dev/stderr | grep -q "^SIMULATION PASSED$$"

clean:
	rm -rf obj_dir

//--- alu.sv
`timescale 1ns/1ns
`default_nettype none

// combinational alu plus branch comparator
module alu
    import exe_pkg::*;
(
    input  wire alu_op_e op_i,
    input  wire word_t   rs1_i,
    input  wire word_t   rs2_i,
    input  wire word_t   imm_i,
    input  wire logic    use_imm_i, // b = imm instead of rs2
    output word_t        result_o,
    output logic         taken_o    // branch condition met
);

    word_t      op_b;     // selected second operand
    logic [4:0] shamt;    // rv32 shift amount
    logic       lt_s;     // slt compare, a vs b
    logic       lt_u;     // sltu compare
    logic       br_eq;    // branch compares always rs1 vs rs2
    logic       br_lt_s;
    logic       br_lt_u;

    // ============================================================
    // operand select and compares
    // ============================================================
    always_comb begin
        op_b    = use_imm_i ? imm_i : rs2_i;
        shamt   = op_b[4:0];
        lt_s    = $signed(rs1_i) < $signed(op_b);
        lt_u    = rs1_i < op_b;
        br_eq   = rs1_i == rs2_i;
        br_lt_s = $signed(rs1_i) < $signed(rs2_i);
        br_lt_u = rs1_i < rs2_i;
    end

    // arithmetic / logic result
    always_comb begin
        case (op_i)
            alu_add:  result_o = rs1_i + op_b;
            alu_sub:  result_o = rs1_i - op_b;
            alu_and:  result_o = rs1_i & op_b;
            alu_or:   result_o = rs1_i | op_b;
            alu_xor:  result_o = rs1_i ^ op_b;
            alu_sll:  result_o = rs1_i << shamt;
            alu_srl:  result_o = rs1_i >> shamt;
            alu_sra:  result_o = word_t'($signed(rs1_i) >>> shamt); // sign fill
            alu_slt:  result_o = {31'b0, lt_s};
            alu_sltu: result_o = {31'b0, lt_u};
            alu_jalr: result_o = rs1_i + imm_i; // target base, always the immediate
            default:  result_o = '0;            // branch compares give no data
        endcase
    end

    // branch decision, low for anything that is not a compare
    always_comb begin
        case (op_i)
            alu_beq:  taken_o = br_eq;
            alu_bne:  taken_o = ~br_eq;
            alu_blt:  taken_o = br_lt_s;
            alu_bge:  taken_o = ~br_lt_s;
            alu_bltu: taken_o = br_lt_u;
            alu_bgeu: taken_o = ~br_lt_u;
            default:  taken_o = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

//--- exe_input.txt
# hex: valid op rs1 rs2 imm use_imm pc_plus4 pred_taken pred_pc is_jalr rd reg_write res_sel illegal
# then: flush | exp redirect redirect_pc flush_if flush_id | exp wb valid rd data illegal
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
1 0 7 5 0 0 104 0 0 0 1 1 0 0 0 0 0 0 0 1 1 c 0
1 1 3 8 0 0 108 0 0 0 2 1 0 0 0 0 0 0 0 1 2 fffffffb 0
1 2 f0f0 0 ff 1 10c 0 0 0 3 1 0 0 0 0 0 0 0 1 3 f0 0
1 3 f00 f 0 0 110 0 0 0 4 1 0 0 0 0 0 0 0 1 4 f0f 0
1 4 ffff0000 0 ffffffff 1 114 0 0 0 5 1 0 0 0 0 0 0 0 1 5 ffff 0
1 5 1 0 1f 1 118 0 0 0 6 1 0 0 0 0 0 0 0 1 6 80000000 0
1 6 80000000 4 0 0 11c 0 0 0 7 1 0 0 0 0 0 0 0 1 7 8000000 0
1 7 80000010 ffffffe4 0 0 120 0 0 0 8 1 0 0 0 0 0 0 0 1 8 f8000001 0
1 8 ffffffff 1 0 0 124 0 0 0 9 1 0 0 0 0 0 0 0 1 9 1 0
1 9 ffffffff 0 1 1 128 0 0 0 a 1 0 0 0 0 0 0 0 1 a 0 0
1 0 0 0 12345000 1 12c 0 0 0 b 1 1 0 0 0 0 0 0 1 b 12345000 0
1 0 0 0 0 0 204 0 0 0 c 1 2 0 0 0 0 0 0 1 c 204 0
1 0 1 1 0 0 208 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0
1 0 1 1 0 0 20c 0 0 0 d 0 0 1 0 0 0 0 0 0 0 0 1
1 10 5 5 0 0 1f4 0 300 0 0 0 0 0 0 1 300 1 1 0 0 0 0
1 11 5 5 0 0 3e4 1 400 0 0 0 0 0 0 1 3e4 1 1 0 0 0 0
1 12 80000000 7fffffff 0 0 404 1 500 0 0 0 0 0 0 0 0 0 0 0 0 0 0
1 15 7fffffff 80000000 0 0 504 0 600 0 0 0 0 0 0 0 0 0 0 0 0 0 0
1 12 7fffffff 80000000 0 0 604 1 700 0 0 0 0 0 0 1 604 1 1 0 0 0 0
1 18 1001 0 2 1 508 0 0 1 1 1 2 0 0 1 1002 1 1 1 1 508 0
1 18 2000 0 ff5 1 60c 1 2ff4 1 1f 1 2 0 0 0 0 0 0 1 1f 60c 0
1 0 10 20 0 0 700 0 0 0 3 1 0 0 0 0 0 0 0 1 3 30 0
1 18 100 0 0 1 704 0 0 1 4 1 2 0 0 0 0 0 0 0 0 0 0
1 0 1 1 0 0 708 0 0 0 5 1 0 0 1 0 0 0 0 0 0 0 0
1 0 1 2 0 0 70c 0 0 0 6 1 0 1 0 0 0 0 0 1 6 3 1
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0

//--- exe_pkg.sv
`default_nettype none

package exe_pkg;

    // ============================================================
    // basic widths, fixed by rv32
    // ============================================================
    typedef logic [31:0] word_t;    // data or address word
    typedef logic [4:0]  reg_idx_t; // x0..x31

    // alu operation, 5 bits, explicit codes so decode and tb agree
    typedef enum logic [4:0] {
        alu_add  = 5'd0,
        alu_sub  = 5'd1,
        alu_and  = 5'd2,
        alu_or   = 5'd3,
        alu_xor  = 5'd4,
        alu_sll  = 5'd5,
        alu_srl  = 5'd6,
        alu_sra  = 5'd7,
        alu_slt  = 5'd8,
        alu_sltu = 5'd9,
        alu_beq  = 5'd16, // branch compares live in the upper half
        alu_bne  = 5'd17,
        alu_blt  = 5'd18,
        alu_bge  = 5'd19,
        alu_bltu = 5'd20,
        alu_bgeu = 5'd21,
        alu_jalr = 5'd24  // rs1 + imm, target computed in exe
    } alu_op_e;

    // writeback source
    typedef enum logic [1:0] {
        res_alu = 2'd0,
        res_imm = 2'd1, // lui style
        res_pc4 = 2'd2  // jal / jalr link value
    } res_sel_e;

    // ============================================================
    // stage bundles
    // ============================================================
    typedef struct packed {
        logic     valid;
        alu_op_e  op;
        word_t    rs1;        // operand a
        word_t    rs2;        // operand b, also branch compare b
        word_t    imm;        // sign extended immediate
        logic     use_imm;    // operand b is imm
        word_t    pc_plus4;
        logic     pred_taken; // static predictor guess
        word_t    pred_pc;    // predictor target
        logic     is_jalr;
        reg_idx_t rd;
        logic     reg_write;
        res_sel_e res_sel;
        logic     illegal;
    } issue_s;

    typedef struct packed {
        logic     valid;
        word_t    alu_result;
        word_t    imm;
        word_t    pc_plus4;
        reg_idx_t rd;
        logic     reg_write;
        res_sel_e res_sel;
        logic     illegal;
    } exe_res_s;

    typedef struct packed {
        logic     valid;   // register file write enable
        reg_idx_t rd;
        word_t    data;
        logic     illegal;
    } wb_s;

    typedef struct packed {
        logic  redirect;    // fetch restarts at redirect_pc
        word_t redirect_pc;
        logic  flush_if;    // kill if/id contents
        logic  flush_id;    // kill id/exe contents
    } redirect_s;

endpackage

`default_nettype wire

//--- exe_stage.sv
`timescale 1ns/1ns
`default_nettype none

// execute stage: result register and branch / jalr resolution
module exe_stage
    import exe_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   rst_i,
    input  wire logic   flush_i,
    input  wire issue_s issue_i,      // registered bundle from id/exe
    input  wire word_t  alu_result_i,
    input  wire logic   alu_taken_i,  // alu branch outcome
    output exe_res_s    res_o,        // to writeback select
    output redirect_s   redirect_o    // to fetch and hazard unit
);

    logic      is_branch;   // op is a compare
    logic      br_wrong;    // predictor disagrees with alu
    logic      jalr_miss;   // jalr without a predicted target
    word_t     jalr_target; // rs1 + imm, bit 0 cleared
    redirect_s redirect_d;  // next redirect request
    exe_res_s  res_q;
    redirect_s redirect_q;

    // ============================================================
    // resolution
    // ============================================================
    always_comb begin
        is_branch   = issue_i.op inside {alu_beq, alu_bne, alu_blt,
                                         alu_bge, alu_bltu, alu_bgeu};
        br_wrong    = issue_i.valid && is_branch &&
                      (issue_i.pred_taken != alu_taken_i);
        jalr_miss   = issue_i.valid && issue_i.is_jalr && !issue_i.pred_taken;
        jalr_target = alu_result_i & ~word_t'(1);

        redirect_d = '0; // correct guess or plain op: nothing
        if (br_wrong) begin
            redirect_d.redirect    = 1'b1;
            // not taken guess but taken -> predictor target
            // taken guess but not taken -> fall through
            redirect_d.redirect_pc = alu_taken_i ? issue_i.pred_pc : issue_i.pc_plus4;
            redirect_d.flush_if    = 1'b1;
            redirect_d.flush_id    = 1'b1;
        end else if (jalr_miss) begin
            redirect_d.redirect    = 1'b1;
            redirect_d.redirect_pc = jalr_target;
            redirect_d.flush_if    = 1'b1;
            redirect_d.flush_id    = 1'b1;
        end
    end

    // ============================================================
    // registers
    // ============================================================
    always_ff @(posedge clk) begin
        // fields writeback needs
        res_q.alu_result <= alu_result_i;
        res_q.imm        <= issue_i.imm;
        res_q.pc_plus4   <= issue_i.pc_plus4;
        res_q.rd         <= issue_i.rd;
        res_q.reg_write  <= issue_i.reg_write;
        res_q.res_sel    <= issue_i.res_sel;
        res_q.illegal    <= issue_i.illegal;

        if (rst_i || flush_i) begin
            res_q.valid <= 1'b0; // killed slot
        end else begin
            res_q.valid <= issue_i.valid;
        end
    end

    // one cycle pulse per mispredicted bundle
    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            redirect_q <= '0;
        end else begin
            redirect_q <= redirect_d;
        end
    end

    assign res_o      = res_q;
    assign redirect_o = redirect_q;

endmodule

`default_nettype wire

//--- exe_tb.sv
`timescale 1ns/1ns
`default_nettype none

// testbench for exe_top, one input file line per issued bundle
module exe_tb
    import exe_pkg::*;
();

    // expected values parked until their edge
    typedef struct packed {
        int        due;      // cycle the result shows up
        int        src_line; // line in exe_input.txt
        redirect_s exp;
    } redirect_entry_t;

    typedef struct packed {
        int  due;
        int  src_line;
        wb_s exp;
    } wb_entry_t;

    // edges from the one that drives the bundle to the one that shows its result
    localparam int redirect_lat = 2;
    localparam int wb_lat       = 3;
    localparam int max_lines    = 500; // read loop limit
    localparam int drain_limit  = 50;

    logic      clk;
    logic      rst_i;
    logic      flush_i;
    issue_s    issue_i;
    redirect_s redirect_o;
    wb_s       wb_o;

    redirect_entry_t exp_redirect_q[$];
    wb_entry_t       exp_wb_q[$];

    int cyc           = 0; // rising edges since reset release
    int err_count     = 0;
    int fail_count    = 0; // input file problems
    int timeout_count = 0;
    int checks_done   = 0;

    tb_clkgen #(.period_ns(20)) u_clkgen (.clk_o(clk));

    exe_top dut0 (
        .clk        (clk),
        .rst_i      (rst_i),
        .flush_i    (flush_i),
        .issue_i    (issue_i),
        .redirect_o (redirect_o),
        .wb_o       (wb_o)
    );

    // ============================================================
    // compare tasks
    // ============================================================
    task automatic check_word(input string ctx, input string name,
                              input word_t got, input word_t exp);
        checks_done++;
        if (got !== exp) begin
            err_count++;
            $display("ERR %0t: %s %s = %h, expected %h", $time, ctx, name, got, exp);
        end
    endtask

    task automatic check_redirect(input string ctx, input redirect_s got,
                                  input redirect_s exp);
        check_word(ctx, "redirect", word_t'(got.redirect), word_t'(exp.redirect));
        check_word(ctx, "redirect_pc", got.redirect_pc, exp.redirect_pc);
        check_word(ctx, "flush_if", word_t'(got.flush_if), word_t'(exp.flush_if));
        check_word(ctx, "flush_id", word_t'(got.flush_id), word_t'(exp.flush_id));
    endtask

    task automatic check_wb(input string ctx, input wb_s got, input wb_s exp);
        check_word(ctx, "wb.valid", word_t'(got.valid), word_t'(exp.valid));
        check_word(ctx, "wb.rd", word_t'(got.rd), word_t'(exp.rd));
        check_word(ctx, "wb.data", got.data, exp.data);
        check_word(ctx, "wb.illegal", word_t'(got.illegal), word_t'(exp.illegal));
    endtask

    // pop whatever is due at this cycle, called at the falling edge
    task automatic compare_due();
        redirect_entry_t re;
        wb_entry_t       we;
        if (exp_redirect_q.size() > 0 && exp_redirect_q[0].due == cyc) begin
            re = exp_redirect_q.pop_front();
            check_redirect($sformatf("line %0d", re.src_line), redirect_o, re.exp);
        end
        if (exp_wb_q.size() > 0 && exp_wb_q[0].due == cyc) begin
            we = exp_wb_q.pop_front();
            check_wb($sformatf("line %0d", we.src_line), wb_o, we.exp);
        end
    endtask

    // ============================================================
    // stimulus
    // ============================================================
    initial begin
        int              fd;
        int              n;
        int              line_no;
        int              drained;
        string           text;
        word_t           col [23];
        issue_s          bundle;
        logic            flush_bit;
        redirect_s       exp_redirect;
        wb_s             exp_wb;
        redirect_entry_t re;
        wb_entry_t       we;

        rst_i   = 1'b1;
        flush_i = 1'b0;
        issue_i = '0;

        // 16 reset edges, outputs must read zero throughout
        for (int i = 0; i < 16; i++) begin
            @(posedge clk);
            if (i == 15) begin
                rst_i <= 1'b0; // last edge still sees reset high
            end
            @(negedge clk);
            check_redirect("reset", redirect_o, '0);
            check_wb("reset", wb_o, '0);
        end

        fd = $fopen("exe_input.txt", "r");
        if (fd == 0) begin
            $display("cannot open exe_input.txt, no stimulus applied");
            fail_count++;
        end else begin
            line_no = 0;
            while (!$feof(fd) && line_no < max_lines) begin
                text = "";
                n = $fgets(text, fd);
                line_no++;
                if (n <= 0 || text.len() == 0 || text[0] == "#") begin
                    continue; // comment or end of file
                end
                n = $sscanf(text,
                    "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    col[0], col[1], col[2], col[3], col[4], col[5], col[6], col[7],
                    col[8], col[9], col[10], col[11], col[12], col[13], col[14], col[15],
                    col[16], col[17], col[18], col[19], col[20], col[21], col[22]);
                if (n <= 0) begin
                    continue; // blank line
                end
                if (n != 23) begin
                    $display("input line %0d has %0d columns instead of 23, skipped",
                             line_no, n);
                    fail_count++;
                    continue;
                end

                bundle.valid      = col[0][0];
                bundle.op         = alu_op_e'(col[1][4:0]);
                bundle.rs1        = col[2];
                bundle.rs2        = col[3];
                bundle.imm        = col[4];
                bundle.use_imm    = col[5][0];
                bundle.pc_plus4   = col[6];
                bundle.pred_taken = col[7][0];
                bundle.pred_pc    = col[8];
                bundle.is_jalr    = col[9][0];
                bundle.rd         = col[10][4:0];
                bundle.reg_write  = col[11][0];
                bundle.res_sel    = res_sel_e'(col[12][1:0]);
                bundle.illegal    = col[13][0];
                flush_bit         = col[14][0]; // kills this bundle and the one ahead

                exp_redirect.redirect    = col[15][0];
                exp_redirect.redirect_pc = col[16];
                exp_redirect.flush_if    = col[17][0];
                exp_redirect.flush_id    = col[18][0];
                exp_wb.valid             = col[19][0];
                exp_wb.rd                = col[20][4:0];
                exp_wb.data              = col[21];
                exp_wb.illegal           = col[22][0];

                @(posedge clk);
                cyc++;
                issue_i <= bundle;
                flush_i <= flush_bit;

                re.due      = cyc + redirect_lat;
                re.src_line = line_no;
                re.exp      = exp_redirect;
                exp_redirect_q.push_back(re);
                we.due      = cyc + wb_lat;
                we.src_line = line_no;
                we.exp      = exp_wb;
                exp_wb_q.push_back(we);

                @(negedge clk);
                compare_due();
            end
            if (!$feof(fd)) begin
                $display("input read stopped after %0d lines, end of file not reached",
                         max_lines);
                timeout_count++;
            end
            $fclose(fd);
        end

        // ============================================================
        // drain, idle bundles until every expected value is seen
        // ============================================================
        drained = 0;
        while ((exp_redirect_q.size() > 0 || exp_wb_q.size() > 0) &&
               drained < drain_limit) begin
            @(posedge clk);
            cyc++;
            issue_i <= '0;
            flush_i <= 1'b0;
            @(negedge clk);
            compare_due();
            drained++;
        end
        if (exp_redirect_q.size() > 0 || exp_wb_q.size() > 0) begin
            $display("pipeline did not drain within %0d cycles", drain_limit);
            timeout_count++;
        end

        $display("errors: %0d  file problems: %0d  timeouts: %0d  checks: %0d",
                 err_count, fail_count, timeout_count, checks_done);
        if (err_count == 0 && fail_count == 0 && timeout_count == 0 && checks_done > 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- exe_top.sv
`timescale 1ns/1ns
`default_nettype none

// execute slice: id/exe reg -> alu + exe -> wb select
module exe_top
    import exe_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   rst_i,
    input  wire logic   flush_i,    // from hazard unit
    input  wire issue_s issue_i,    // from decode
    output redirect_s   redirect_o, // edge n+2
    output wb_s         wb_o        // edge n+3
);

    // ============================================================
    // internal nets
    // ============================================================
    issue_s   issue_q;      // registered decode bundle
    word_t    alu_result;
    logic     alu_taken;
    exe_res_s exe_res;

    id_exe_reg u_id_exe_reg (
        .clk     (clk),
        .rst_i   (rst_i),
        .flush_i (flush_i),
        .issue_i (issue_i),
        .issue_o (issue_q)
    );

    // purely combinational, same cycle as issue_q
    alu u_alu (
        .op_i      (issue_q.op),
        .rs1_i     (issue_q.rs1),
        .rs2_i     (issue_q.rs2),
        .imm_i     (issue_q.imm),
        .use_imm_i (issue_q.use_imm),
        .result_o  (alu_result),
        .taken_o   (alu_taken)
    );

    exe_stage u_exe_stage (
        .clk          (clk),
        .rst_i        (rst_i),
        .flush_i      (flush_i),
        .issue_i      (issue_q),
        .alu_result_i (alu_result),
        .alu_taken_i  (alu_taken),
        .res_o        (exe_res),
        .redirect_o   (redirect_o)
    );

    wb_select u_wb_select (
        .clk   (clk),
        .rst_i (rst_i),
        .res_i (exe_res),
        .wb_o  (wb_o)
    );

endmodule

`default_nettype wire

//--- id_exe_reg.sv
`timescale 1ns/1ns
`default_nettype none

// id/exe boundary, one decoded bundle per cycle, no stall
module id_exe_reg
    import exe_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   rst_i,
    input  wire logic   flush_i,  // from hazard unit
    input  wire issue_s issue_i,  // from decode
    output issue_s      issue_o   // to alu and exe
);

    // ============================================================
    // bundle register
    // ============================================================
    issue_s issue_q;

    always_ff @(posedge clk) begin
        // payload follows decode every cycle
        issue_q <= issue_i;

        // only the valid bit matters for a killed slot
        if (rst_i || flush_i) begin
            issue_q.valid <= 1'b0;
        end
    end

    assign issue_o = issue_q; // one cycle after decode

endmodule

`default_nettype wire

//--- tb_clkgen.sv
`timescale 1ns/1ns
`default_nettype none

// free running testbench clock
module tb_clkgen #(
    parameter int period_ns = 20
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0; // first rising edge at half a period
        forever begin
            #(period_ns / 2) clk_o = ~clk_o;
        end
    end

endmodule

`default_nettype wire

//--- verilog.f
exe_pkg.sv
id_exe_reg.sv
alu.sv
exe_stage.sv
wb_select.sv
exe_top.sv
tb_clkgen.sv
exe_tb.sv

//--- wb_select.sv
`timescale 1ns/1ns
`default_nettype none

// writeback select, last register before the register file
module wb_select
    import exe_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst_i,
    input  wire exe_res_s res_i,
    output wb_s           wb_o
);

    logic  wr_en;   // real write this cycle
    word_t wr_data;
    wb_s   wb_q;

    always_comb begin
        // x0 is hardwired, never written
        wr_en = res_i.valid && res_i.reg_write && (res_i.rd != reg_idx_t'(0));

        case (res_i.res_sel)
            res_imm: wr_data = res_i.imm;
            res_pc4: wr_data = res_i.pc_plus4; // link address
            default: wr_data = res_i.alu_result;
        endcase
    end

    // ============================================================
    // writeback register
    // ============================================================
    always_ff @(posedge clk) begin
        if (rst_i) begin
            wb_q <= '0;
        end else begin
            wb_q.valid   <= wr_en;
            wb_q.rd      <= wr_en ? res_i.rd : '0;  // idle bus reads as zero
            wb_q.data    <= wr_en ? wr_data : '0;
            wb_q.illegal <= res_i.valid && res_i.illegal; // flagged with any live bundle
        end
    end

    assign wb_o = wb_q;

endmodule

`default_nettype wire
